/* bench/tb_midi_voice.sv */
////////////////////////////////////////
// testbench for the MIDI voice front end with serial
// and CPU drivers, reference voice model and comparator
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_midi_voice;

	localparam int voices       = 4;
	localparam int clks_per_bit = 16;
	localparam int clk_ns       = 40;
	localparam int total_bytes  = 200;                 // upper bound of bytes sent by all tests
	localparam longint timeout_ns = longint'(total_bytes) * 10 * clks_per_bit * clk_ns * 2
	                                + 400_000;         // double frame time plus drain waits

	typedef struct packed {
		logic       on;
		logic [1:0] voice;
		logic [6:0] key;
		logic [6:0] vel;
	} note_t;

	logic io_clk, io_reset, midi_rxd, cpu_read, cpu_write, note_ready;
	logic [2:0] address;
	logic [7:0] writedata, readdata;
	logic note_valid, note_on;
	logic [1:0] note_voice;
	logic [6:0] note_key, note_vel;
	logic [voices-1:0] keys_on;

	logic [voices-1:0] model_busy;                    // reference slot table
	logic [6:0] model_key [voices];
	note_t exp_q [$];                                 // expected events in arrival order
	note_t got;
	int err_cnt, test_err_base, tests_ok, tests_bad, exp_dropped;
	string cur_test;
	bit seq_done;

	midi_voice_top #(.voices(voices), .clks_per_bit(clks_per_bit)) UUT (
		.io_clk(io_clk), .io_reset(io_reset), .midi_rxd(midi_rxd), .cpu_read(cpu_read),
		.cpu_write(cpu_write), .address(address), .writedata(writedata), .readdata(readdata),
		.note_valid(note_valid), .note_ready(note_ready), .note_on(note_on),
		.note_voice(note_voice), .note_key(note_key), .note_vel(note_vel), .keys_on(keys_on)
	);

	initial begin
		io_clk = 1'b0;
		forever #(clk_ns / 2) io_clk = ~io_clk;
	end

	initial begin                                     // watchdog
		#(timeout_ns);
		$display("watchdog expired, tests did not complete in time");
		$display("Simulation failed");
		$finish;
	end

	task automatic report_mismatch(input string what, input logic [31:0] expv,
	                               input logic [31:0] actv);
		$display("FAILED %s %s: expected %0h, actual %0h", cur_test, what, expv, actv);
		err_cnt++;
	endtask

	// lowest free slot on note-on or lowest matching busy slot on note-off
	// returns -1 when no slot applies
	function automatic int ref_alloc(input bit on, input logic [6:0] key);
		for (int i = 0; i < voices; i++) begin
			if (on && !model_busy[i]) begin
				model_busy[i] = 1'b1;
				model_key[i]  = key;
				return i;
			end
			if (!on && model_busy[i] && model_key[i] == key) begin
				model_busy[i] = 1'b0;
				return i;
			end
		end
		return -1;
	endfunction

	task automatic expect_note(input bit on, input logic [6:0] key, input logic [6:0] vel);
		note_t n;
		int v;
		v = ref_alloc(on, key);
		if (v >= 0) begin
			n.on    = on;
			n.voice = 2'(v);
			n.key   = key;
			n.vel   = vel;
			exp_q.push_back(n);
		end else if (on) exp_dropped++;           // all voices busy
	endtask

	////////////////////////////////////////
	// stimulus drivers, falling edge
	////////////////////////////////////////
	task automatic send_byte(input logic [7:0] b, input bit bad_stop);
		@(negedge io_clk);
		midi_rxd = 1'b0;                              // start bit
		repeat (clks_per_bit) @(negedge io_clk);
		for (int i = 0; i < 8; i++) begin
			midi_rxd = b[i];                          // lsb first
			repeat (clks_per_bit) @(negedge io_clk);
		end
		midi_rxd = !bad_stop;
		repeat (clks_per_bit) @(negedge io_clk);
		midi_rxd = 1'b1;                              // one idle bit
		repeat (clks_per_bit - 1) @(negedge io_clk);
	endtask

	task automatic note_msg(input logic [3:0] cmd, input logic [3:0] ch, input logic [6:0] key,
	                        input logic [6:0] vel, input bit expect_ev);
		if (expect_ev) expect_note(cmd == midi_pkg::cmd_note_on && vel != 0, key, vel);
		send_byte({cmd, ch}, 1'b0);
		send_byte({1'b0, key}, 1'b0);
		send_byte({1'b0, vel}, 1'b0);
	endtask

	task automatic data_pair(input logic [6:0] key, input logic [6:0] vel, input bit rt_mid);
		expect_note(vel != 0, key, vel);              // running status note-on
		send_byte({1'b0, key}, 1'b0);
		if (rt_mid) send_byte(midi_pkg::sys_realtime_min, 1'b0);  // timing clock
		send_byte({1'b0, vel}, 1'b0);
	endtask

	task automatic reg_write(input logic [2:0] a, input logic [7:0] d);
		@(negedge io_clk);
		cpu_write = 1'b1;
		address   = a;
		writedata = d;
		@(negedge io_clk);
		cpu_write = 1'b0;
	endtask

	task automatic reg_read(input logic [2:0] a, output logic [7:0] d);
		@(negedge io_clk);
		cpu_read = 1'b1;
		address  = a;
		@(negedge io_clk);
		d        = readdata;                          // loaded at the edge in between
		cpu_read = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 400) begin
			@(negedge io_clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("ERROR %s: %0d expected note events never arrived", cur_test, exp_q.size());
			err_cnt++;
		end
		repeat (20) @(negedge io_clk);                // room for stray events
	endtask

	task automatic release_all();
		for (int v = 0; v < voices; v++)
			if (model_busy[v]) note_msg(midi_pkg::cmd_note_off, 4'h0, model_key[v], 7'd0, 1'b1);
		wait_drain();
	endtask

	task automatic toggle_ready();
		int stretch;
		stretch = 0;
		while (!seq_done) begin
			@(negedge io_clk);
			if (stretch == 0) begin
				note_ready = ~note_ready;
				stretch    = $urandom_range(1, 20);
			end else stretch--;
		end
		note_ready = 1'b1;
	endtask

	task automatic start_test(input string name);
		cur_test      = name;
		test_err_base = err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt == test_err_base) begin
			$display("test %s: ok", cur_test);
			tests_ok++;
		end else begin
			$display("test %s: %0d errors", cur_test, err_cnt - test_err_base);
			tests_bad++;
		end
	endtask

	// handshake inputs settle at the falling edge before this sample
	always @(posedge io_clk) begin
		if (!io_reset && note_valid && note_ready) begin
			if (exp_q.size() == 0) begin
				$display("ERROR %s: unexpected note event, key %0d on voice %0d",
				         cur_test, note_key, note_voice);
				err_cnt++;
			end else begin
				got = exp_q.pop_front();
				if (note_on !== got.on) report_mismatch("note_on", got.on, note_on);
				if (note_voice !== got.voice) report_mismatch("note_voice", got.voice, note_voice);
				if (note_key !== got.key) report_mismatch("note_key", got.key, note_key);
				if (note_vel !== got.vel) report_mismatch("note_vel", got.vel, note_vel);
			end
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin
		logic [7:0] rd;
		logic [6:0] key;
		void'($urandom(32'hf5644a2f));
		io_reset    = 1'b1;
		midi_rxd    = 1'b1;
		cpu_read    = 1'b0;
		cpu_write   = 1'b0;
		address     = '0;
		writedata   = '0;
		note_ready  = 1'b1;
		model_busy  = '0;
		err_cnt     = 0;
		tests_ok    = 0;
		tests_bad   = 0;
		exp_dropped = 0;
		repeat (8) @(negedge io_clk);
		io_reset = 1'b0;

		start_test("registers");
		reg_read(synth_pkg::reg_midi_ch, rd);
		if (rd !== 8'h10) report_mismatch("midi_ch after reset", 8'h10, rd);
		for (int a = 1; a < 8; a++) begin              // counters and unmapped words
			reg_read(3'(a), rd);
			if (rd !== 8'h00) report_mismatch($sformatf("addr %0d", a), 8'h00, rd);
		end
		reg_write(synth_pkg::reg_midi_ch, 8'h03);
		reg_read(synth_pkg::reg_midi_ch, rd);
		if (rd !== 8'h03) report_mismatch("midi_ch readback", 8'h03, rd);
		reg_write(synth_pkg::reg_midi_ch, 8'h10);
		end_test();

		start_test("allocation");
		note_msg(midi_pkg::cmd_note_on, 4'h0, 7'd60, 7'd100, 1'b1);
		note_msg(midi_pkg::cmd_note_on, 4'h0, 7'd64, 7'd90, 1'b1);
		note_msg(midi_pkg::cmd_note_on, 4'h0, 7'd67, 7'd80, 1'b1);
		wait_drain();
		reg_read(synth_pkg::reg_active, rd);
		if (rd !== 8'd3) report_mismatch("reg_active", 8'd3, rd);
		if (keys_on !== model_busy) report_mismatch("keys_on", model_busy, keys_on);
		note_msg(midi_pkg::cmd_note_off, 4'h0, 7'd64, 7'd40, 1'b1);   // frees voice 1
		note_msg(midi_pkg::cmd_note_on, 4'h0, 7'd72, 7'd70, 1'b1);    // takes voice 1
		wait_drain();
		if (keys_on !== model_busy) report_mismatch("keys_on", model_busy, keys_on);
		release_all();
		end_test();

		start_test("running status");
		send_byte({midi_pkg::cmd_note_on, 4'h0}, 1'b0);
		data_pair(7'd50, 7'd70, 1'b0);
		data_pair(7'd52, 7'd71, 1'b1);
		data_pair(7'd54, 7'd72, 1'b1);
		data_pair(7'd50, 7'd0, 1'b0);                 // velocity 0 releases
		data_pair(7'd52, 7'd0, 1'b0);
		data_pair(7'd54, 7'd0, 1'b0);
		send_byte({midi_pkg::cmd_prog_change, 4'h0}, 1'b0);
		send_byte(8'h05, 1'b0);                       // single data byte
		note_msg(midi_pkg::cmd_note_on, 4'h0, 7'd55, 7'd60, 1'b1);
		release_all();
		end_test();

		start_test("channel filter");
		reg_write(synth_pkg::reg_midi_ch, 8'h03);
		note_msg(midi_pkg::cmd_note_on, 4'h1, 7'd40, 7'd50, 1'b0);
		note_msg(midi_pkg::cmd_note_on, 4'hF, 7'd41, 7'd50, 1'b0);
		note_msg(midi_pkg::cmd_note_on, 4'h3, 7'd42, 7'd50, 1'b1);
		note_msg(midi_pkg::cmd_note_off, 4'h3, 7'd42, 7'd0, 1'b1);
		wait_drain();
		reg_write(synth_pkg::reg_midi_ch, 8'h10);
		note_msg(midi_pkg::cmd_note_on, 4'h5, 7'd43, 7'd50, 1'b1);
		note_msg(midi_pkg::cmd_note_on, 4'hA, 7'd44, 7'd50, 1'b1);
		note_msg(midi_pkg::cmd_note_off, 4'h5, 7'd43, 7'd0, 1'b1);
		note_msg(midi_pkg::cmd_note_off, 4'hA, 7'd44, 7'd0, 1'b1);
		wait_drain();
		end_test();

		start_test("overflow and backpressure");
		seq_done = 1'b0;
		fork
			begin
				for (int i = 0; i < 20; i++) begin
					key = 7'(36 + $urandom_range(0, 7));  // narrow range so offs hit
					note_msg($urandom_range(0, 1) ? midi_pkg::cmd_note_on : midi_pkg::cmd_note_off,
					         4'h0, key, 7'(1 + $urandom_range(0, 126)), 1'b1);
				end
				seq_done = 1'b1;
			end
			toggle_ready();
		join
		wait_drain();
		reg_read(synth_pkg::reg_dropped, rd);
		if (rd !== 8'(exp_dropped)) report_mismatch("reg_dropped random", exp_dropped, rd);
		release_all();
		for (int i = 0; i < voices + 1; i++)          // fifth one is refused
			note_msg(midi_pkg::cmd_note_on, 4'h0, 7'(80 + i), 7'd90, 1'b1);
		wait_drain();
		reg_read(synth_pkg::reg_dropped, rd);
		if (rd !== 8'(exp_dropped)) report_mismatch("reg_dropped full", exp_dropped, rd);
		reg_write(synth_pkg::reg_dropped, 8'h00);
		exp_dropped = 0;
		reg_read(synth_pkg::reg_dropped, rd);
		if (rd !== 8'h00) report_mismatch("reg_dropped cleared", 8'h00, rd);
		release_all();
		end_test();

		start_test("framing error");
		send_byte({midi_pkg::cmd_note_on, 4'h2}, 1'b0);
		send_byte({1'b0, 7'd45}, 1'b0);
		send_byte({1'b0, 7'd55}, 1'b1);               // velocity with stop bit low, no event
		wait_drain();
		reg_read(synth_pkg::reg_frame_err, rd);
		if (rd !== 8'd1) report_mismatch("reg_frame_err", 8'd1, rd);
		note_msg(midi_pkg::cmd_note_on, 4'h2, 7'd45, 7'd55, 1'b1);
		note_msg(midi_pkg::cmd_note_off, 4'h2, 7'd45, 7'd20, 1'b1);
		wait_drain();
		reg_read(synth_pkg::reg_frame_err, rd);
		if (rd !== 8'd1) report_mismatch("reg_frame_err after good", 8'd1, rd);
		end_test();

		$display("tests run %0d, ok %0d, failed %0d, errors %0d",
		         tests_ok + tests_bad, tests_ok, tests_bad, err_cnt);
		if (err_cnt == 0) $display("Simulation passed");
		else $display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src/ctrl_regs.sv */
////////////////////////////////////////
// CPU registers: channel setting, busy voice
// count, drop and framing error counters
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs #(
	parameter int voices = 8
) (
	input  wire logic                 io_clk,
	input  wire logic                 io_reset,
	input  wire logic                 cpu_read,
	input  wire logic                 cpu_write,
	input  wire synth_pkg::reg_addr_t address,
	input  wire synth_pkg::reg_data_t writedata,
	output synth_pkg::reg_data_t      readdata,       // one cycle after read
	output logic [4:0]                midi_ch,        // to parser filter
	input  wire logic [voices-1:0]    keys_on,
	input  wire logic                 drops,
	input  wire logic                 rx_frame_err
);

	synth_pkg::reg_data_t active_cnt;                 // busy voices
	synth_pkg::reg_data_t dropped_cnt;
	synth_pkg::reg_data_t frame_err_cnt;

	always_comb begin
		active_cnt = '0;
		for (int i = 0; i < voices; i++) active_cnt = active_cnt + keys_on[i];
	end

	always_ff @(posedge io_clk) begin
		if (io_reset) begin
			midi_ch       <= synth_pkg::midi_ch_reset;
			dropped_cnt   <= '0;
			frame_err_cnt <= '0;
		end else begin
			if (cpu_write && address == synth_pkg::reg_midi_ch) midi_ch <= writedata[4:0];
			if (cpu_write && address == synth_pkg::reg_dropped) dropped_cnt <= '0;  // wr wins
			else if (drops && dropped_cnt != synth_pkg::cnt_max)
				dropped_cnt <= dropped_cnt + 1'b1;
			if (cpu_write && address == synth_pkg::reg_frame_err) frame_err_cnt <= '0;
			else if (rx_frame_err && frame_err_cnt != synth_pkg::cnt_max)
				frame_err_cnt <= frame_err_cnt + 1'b1;
		end
	end

	// registered read mux
	always_ff @(posedge io_clk) begin
		if (cpu_read) begin
			case (address)
				synth_pkg::reg_midi_ch:   readdata <= synth_pkg::reg_data_t'(midi_ch);
				synth_pkg::reg_active:    readdata <= active_cnt;
				synth_pkg::reg_dropped:   readdata <= dropped_cnt;
				synth_pkg::reg_frame_err: readdata <= frame_err_cnt;
				default:                  readdata <= '0;  // unmapped
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/midi_msg_parser.sv */
////////////////////////////////////////
// MIDI message parser with running status,
// channel filter and note event output
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module midi_msg_parser (
	input  wire logic       io_clk,
	input  wire logic       io_reset,
	input  wire logic [7:0] rx_data,
	input  wire logic       rx_valid,                 // one byte per pulse
	input  wire logic [4:0] midi_ch,                  // [4] omni, [3:0] channel
	output logic            ev_valid,
	input  wire logic       ev_ready,
	output logic            ev_on,                    // 0 is note-off
	output logic [6:0]      ev_key,
	output logic [6:0]      ev_vel
);

	midi_pkg::status_byte_u in_st;                    // incoming byte
	midi_pkg::status_byte_u run_st;                   // running status
	logic       run_ok;                               // running status usable
	logic [1:0] data_cnt;                             // data bytes so far
	logic [1:0] data_need;                            // data bytes of this command
	logic [6:0] data1;                                // first data byte, the key
	logic       is_data, is_note, ch_match, msg_done, take;

	assign in_st = rx_data;

	always_comb begin
		data_need = midi_pkg::data_len_long;
		if (run_st.ch.cmd == midi_pkg::cmd_prog_change ||
		    run_st.ch.cmd == midi_pkg::cmd_chan_pressure)
			data_need = midi_pkg::data_len_short;
	end

	assign is_data  = rx_valid && !rx_data[7];
	assign msg_done = is_data && run_ok && (data_cnt == data_need - 2'd1);
	assign is_note  = (run_st.ch.cmd == midi_pkg::cmd_note_on) ||
	                  (run_st.ch.cmd == midi_pkg::cmd_note_off);
	assign ch_match = midi_ch[4] || (run_st.ch.chan == midi_ch[3:0]);
	// byte lost if previous event still pending
	assign take     = msg_done && is_note && ch_match && (!ev_valid || ev_ready);

	////////////////////////////////////////
	// control state
	////////////////////////////////////////
	always_ff @(posedge io_clk) begin
		if (io_reset) begin
			run_ok   <= 1'b0;
			data_cnt <= '0;
			ev_valid <= 1'b0;
		end else begin
			if (ev_valid && ev_ready) ev_valid <= 1'b0;   // handed to allocator
			if (take) ev_valid <= 1'b1;
			if (rx_valid && rx_data[7]) begin
				if (in_st.code < midi_pkg::sys_realtime_min) begin  // realtime leaves all
					data_cnt <= '0;
					run_ok   <= (in_st.code < midi_pkg::sys_code_min);  // sys clears
				end
			end else if (is_data && run_ok) begin
				if (msg_done) data_cnt <= '0;             // same status, next message
				else data_cnt <= data_cnt + 2'd1;
			end
		end
	end

	////////////////////////////////////////
	// payload
	////////////////////////////////////////
	always_ff @(posedge io_clk) begin
		if (rx_valid && rx_data[7] && in_st.code < midi_pkg::sys_code_min)
			run_st <= in_st;                              // channel status only
		if (is_data && data_cnt == 2'd0)
			data1 <= rx_data[6:0];
		if (take) begin
			ev_on  <= (run_st.ch.cmd == midi_pkg::cmd_note_on) && (rx_data[6:0] != 7'd0);
			ev_key <= data1;
			ev_vel <= rx_data[6:0];                       // release vel on note-off
		end
	end

endmodule

`default_nettype wire

/* src/midi_pkg.sv */
////////////////////////////////////////
// MIDI protocol definitions: status byte union,
// command codes, system code limits, data lengths
////////////////////////////////////////
`default_nettype none

package midi_pkg;

	// channel message view of a status byte
	typedef struct packed {
		logic [3:0] cmd;                              // upper nibble, command
		logic [3:0] chan;                             // lower nibble, channel 0..15
	} chan_status_t;

	// one status byte, read per message class
	typedef union packed {
		chan_status_t ch;                             // 0x80..0xEF
		logic [7:0]   code;                           // 0xF0..0xFF system codes
	} status_byte_u;

	// channel command nibbles
	localparam logic [3:0] cmd_note_off      = 4'h8;
	localparam logic [3:0] cmd_note_on       = 4'h9;
	localparam logic [3:0] cmd_prog_change   = 4'hC;
	localparam logic [3:0] cmd_chan_pressure = 4'hD;

	////////////////////////////////////////
	// system code ranges
	////////////////////////////////////////
	localparam logic [7:0] sys_code_min     = 8'hF0;  // start of system messages
	localparam logic [7:0] sys_realtime_min = 8'hF8;  // clock, start, stop, sense...

	// data bytes per channel message
	localparam logic [1:0] data_len_short = 2'd1;     // prog change, chan pressure
	localparam logic [1:0] data_len_long  = 2'd2;     // everything else

endpackage

`default_nettype wire

/* src/midi_uart_rx.sv */
////////////////////////////////////////
// MIDI serial receiver, 8N1, oversampled,
// byte strobe and framing error strobe
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module midi_uart_rx #(
	parameter int clks_per_bit = 800                  // io_clk cycles per bit
) (
	input  wire logic       io_clk,
	input  wire logic       io_reset,
	input  wire logic       midi_rxd,                 // idles high
	output logic [7:0]      rx_data,
	output logic            rx_valid,                 // one cycle, good stop bit
	output logic            rx_frame_err              // one cycle, stop bit low
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);
	localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);

	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_start = 2'd1;
	localparam logic [1:0] st_data  = 2'd2;
	localparam logic [1:0] st_stop  = 2'd3;

	logic             rxd_meta, rxd_sync, rxd_prev;   // two flop sync plus edge history
	logic [1:0]       state;
	logic [cnt_w-1:0] clk_cnt;                        // cycles within current bit
	logic [2:0]       bit_idx;                        // data bit being sampled
	logic [7:0]       shift;

	assign rx_data = shift;                           // stable until next frame's data

	always_ff @(posedge io_clk) begin
		if (io_reset) begin
			rxd_meta     <= 1'b1;
			rxd_sync     <= 1'b1;
			rxd_prev     <= 1'b1;
			state        <= st_idle;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			rx_valid     <= 1'b0;
			rx_frame_err <= 1'b0;
		end else begin
			rxd_meta     <= midi_rxd;
			rxd_sync     <= rxd_meta;
			rxd_prev     <= rxd_sync;
			rx_valid     <= 1'b0;                     // strobes by default low
			rx_frame_err <= 1'b0;
			clk_cnt      <= clk_cnt + 1'b1;
			case (state)
				st_idle: begin
					clk_cnt <= '0;
					if (rxd_prev && !rxd_sync) state <= st_start;  // falling start edge
				end
				st_start: if (clk_cnt == half_cnt) begin          // middle of start bit
					clk_cnt <= '0;
					bit_idx <= '0;
					state   <= rxd_sync ? st_idle : st_data;      // glitch, back to idle
				end
				st_data: if (clk_cnt == full_cnt) begin
					clk_cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) state <= st_stop;
				end
				default: if (clk_cnt == full_cnt) begin           // middle of stop bit
					state        <= st_idle;
					rx_valid     <= rxd_sync;
					rx_frame_err <= !rxd_sync;
				end
			endcase
		end
	end

	// lsb first shift, sampled mid bit
	always_ff @(posedge io_clk) begin
		if (state == st_data && clk_cnt == full_cnt) shift <= {rxd_sync, shift[7:1]};
	end

endmodule

`default_nettype wire

/* src/midi_voice_top.sv */
////////////////////////////////////////
// MIDI voice front end top level, receiver,
// parser, allocator and CPU registers
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module midi_voice_top #(
	parameter int voices       = 8,                   // voice slots
	parameter int clks_per_bit = 800                  // 25 MHz at 31250 baud
) (
	input  wire logic                  io_clk,
	input  wire logic                  io_reset,
	input  wire logic                  midi_rxd,
	input  wire logic                  cpu_read,
	input  wire logic                  cpu_write,
	input  wire synth_pkg::reg_addr_t  address,
	input  wire synth_pkg::reg_data_t  writedata,
	output synth_pkg::reg_data_t       readdata,
	output logic                       note_valid,
	input  wire logic                  note_ready,
	output logic                       note_on,
	output logic [$clog2(voices)-1:0]  note_voice,
	output logic [6:0]                 note_key,
	output logic [6:0]                 note_vel,
	output logic [voices-1:0]          keys_on
);

	logic [7:0] rx_data;                              // uart to parser
	logic       rx_valid, rx_frame_err;
	logic [4:0] midi_ch;                              // regs to parser
	logic       ev_valid, ev_ready, ev_on;            // parser to allocator
	logic [6:0] ev_key, ev_vel;
	logic       drops;

	midi_uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
		.io_clk(io_clk), .io_reset(io_reset), .midi_rxd(midi_rxd),
		.rx_data(rx_data), .rx_valid(rx_valid), .rx_frame_err(rx_frame_err)
	);

	midi_msg_parser u_parser (
		.io_clk(io_clk), .io_reset(io_reset), .rx_data(rx_data), .rx_valid(rx_valid),
		.midi_ch(midi_ch), .ev_valid(ev_valid), .ev_ready(ev_ready), .ev_on(ev_on),
		.ev_key(ev_key), .ev_vel(ev_vel)
	);

	voice_allocator #(.voices(voices)) u_alloc (
		.io_clk(io_clk), .io_reset(io_reset), .ev_valid(ev_valid), .ev_ready(ev_ready),
		.ev_on(ev_on), .ev_key(ev_key), .ev_vel(ev_vel), .note_valid(note_valid),
		.note_ready(note_ready), .note_on(note_on), .note_voice(note_voice),
		.note_key(note_key), .note_vel(note_vel), .keys_on(keys_on), .drops(drops)
	);

	ctrl_regs #(.voices(voices)) u_regs (
		.io_clk(io_clk), .io_reset(io_reset), .cpu_read(cpu_read), .cpu_write(cpu_write),
		.address(address), .writedata(writedata), .readdata(readdata), .midi_ch(midi_ch),
		.keys_on(keys_on), .drops(drops), .rx_frame_err(rx_frame_err)
	);

endmodule

`default_nettype wire

/* src/synth_pkg.sv */
////////////////////////////////////////
// CPU register map and register word of
// the voice front end
////////////////////////////////////////
`default_nettype none

package synth_pkg;

	typedef logic [2:0] reg_addr_t;                   // cpu word address
	typedef logic [7:0] reg_data_t;                   // cpu data word

	////////////////////////////////////////
	// register addresses
	////////////////////////////////////////
	localparam reg_addr_t reg_midi_ch   = 3'd0;       // rw, [3:0] chan, [4] omni
	localparam reg_addr_t reg_active    = 3'd1;       // ro, busy voices
	localparam reg_addr_t reg_dropped   = 3'd2;       // ro, refused note-ons, wr clears
	localparam reg_addr_t reg_frame_err = 3'd3;       // ro, framing errors, wr clears

	localparam reg_data_t cnt_max       = 8'hFF;      // counters stick here
	localparam logic [4:0] midi_ch_reset = 5'h10;     // omni after reset

endpackage

`default_nettype wire

/* src/voice_allocator.sv */
////////////////////////////////////////
// voice slot table, lowest free slot on note-on,
// release on note-off, one-deep output register
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module voice_allocator #(
	parameter int voices = 8                          // number of voice slots
) (
	input  wire logic                       io_clk,
	input  wire logic                       io_reset,
	input  wire logic                       ev_valid,
	output logic                            ev_ready,
	input  wire logic                       ev_on,
	input  wire logic [6:0]                 ev_key,
	input  wire logic [6:0]                 ev_vel,
	output logic                            note_valid,
	input  wire logic                       note_ready,
	output logic                            note_on,
	output logic [$clog2(voices)-1:0]       note_voice,
	output logic [6:0]                      note_key,
	output logic [6:0]                      note_vel,
	output logic [voices-1:0]               keys_on,  // busy bit per slot
	output logic                            drops     // note-on refused
);

	localparam int vw = $clog2(voices);

	logic [6:0]    slot_key [voices];                 // key held by each slot
	logic          free_hit, match_hit;
	logic [vw-1:0] free_idx, match_idx;
	logic          ev_fire, load;

	////////////////////////////////////////
	// slot search, lowest index wins
	////////////////////////////////////////
	always_comb begin
		free_hit  = 1'b0;
		free_idx  = '0;
		match_hit = 1'b0;
		match_idx = '0;
		for (int i = voices - 1; i >= 0; i--) begin   // downward so lowest sticks
			if (!keys_on[i]) begin
				free_hit = 1'b1;
				free_idx = vw'(i);
			end
			if (keys_on[i] && slot_key[i] == ev_key) begin
				match_hit = 1'b1;
				match_idx = vw'(i);
			end
		end
	end

	assign ev_ready = !note_valid || note_ready;      // empty or draining now
	assign ev_fire  = ev_valid && ev_ready;
	assign load     = ev_fire && (ev_on ? free_hit : match_hit);  // stray off is silent

	always_ff @(posedge io_clk) begin
		if (io_reset) begin
			keys_on    <= '0;
			note_valid <= 1'b0;
			drops      <= 1'b0;
		end else begin
			drops <= 1'b0;
			if (note_valid && note_ready) note_valid <= 1'b0;
			if (load) note_valid <= 1'b1;
			if (ev_fire) begin
				if (ev_on && free_hit) keys_on[free_idx] <= 1'b1;   // claim slot
				else if (ev_on) drops <= 1'b1;                      // all busy
				else if (match_hit) keys_on[match_idx] <= 1'b0;    // release
			end
		end
	end

	// slot keys and output payload
	always_ff @(posedge io_clk) begin
		if (ev_fire && ev_on && free_hit) slot_key[free_idx] <= ev_key;
		if (load) begin
			note_on    <= ev_on;
			note_voice <= ev_on ? free_idx : match_idx;
			note_key   <= ev_key;
			note_vel   <= ev_vel;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
src/midi_pkg.sv
src/synth_pkg.sv
src/midi_uart_rx.sv
src/midi_msg_parser.sv
src/voice_allocator.sv
src/ctrl_regs.sv
src/midi_voice_top.sv
bench/tb_midi_voice.sv
